// ==== verilog/axi_sram_config.svh ====
`ifndef AXI_SRAM_CONFIG_SVH
`define AXI_SRAM_CONFIG_SVH

// axi transaction id width.
`define AXI_ID_BITS 4

// byte address width on the ar and aw channels.
`define AXI_ADDR_BITS 32

// data bus width.
`define AXI_DATA_BITS 32

// one strobe bit per data byte.
`define AXI_STRB_BITS 4

// burst length field, a burst carries len + 1 beats.
`define AXI_LEN_BITS 4

// word address into the sram, taken from byte address bits 15:2.
`define SRAM_ADDR_BITS 14

// number of 32-bit words, 64 KiB in total.
`define SRAM_DEPTH 16384

// lowest byte address bit that selects a word.
`define SRAM_WORD_LSB 2

`endif

// ==== verilog/axi_sram_pkg.sv ====
`include "axi_sram_config.svh"

package axi_sram_pkg;

  // axi response codes.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

  // controller states.
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_write = 2'd1,
    st_resp  = 2'd2,
    st_read  = 2'd3
  } ctrl_state_e;

  // write address channel.
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
  } axi_aw_t;

  // read address channel, same layout as aw.
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
  } axi_ar_t;

  // write data channel.
  typedef struct packed {
    logic [`AXI_DATA_BITS-1:0] data;
    logic [`AXI_STRB_BITS-1:0] strb;
    logic                      last;
  } axi_w_t;

  // write response channel.
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
    axi_resp_e               resp;
  } axi_b_t;

  // read data channel.
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_DATA_BITS-1:0] data;
    axi_resp_e                 resp;
    logic                      last;
  } axi_r_t;

  // sram request, web bits are active low per byte.
  typedef struct packed {
    logic                       cs;
    logic                       oe;
    logic [`AXI_STRB_BITS-1:0]  web;
    logic [`SRAM_ADDR_BITS-1:0] addr;
    logic [`AXI_DATA_BITS-1:0]  din;
  } sram_req_t;

endpackage

// ==== verilog/sram_sp.sv ====
`timescale 1ns/1ps
`include "axi_sram_config.svh"

module sram_sp
  import axi_sram_pkg::*;
(
  input  logic                      clk,
  input  sram_req_t                 req,
  output logic [`AXI_DATA_BITS-1:0] dout
);

  logic [`AXI_DATA_BITS-1:0] mem [`SRAM_DEPTH];

  // byte-wise write, only lanes with web low are touched.
  always_ff @(posedge clk) begin
    if (req.cs) begin
      for (int i = 0; i < `AXI_STRB_BITS; i++) begin
        if (!req.web[i]) begin
          mem[req.addr][8*i +: 8] <= req.din[8*i +: 8];
        end
      end
    end
  end

  // registered read port.
  // dout keeps its last value when not reading, so a stalled beat stays put.
  always_ff @(posedge clk) begin
    if (req.cs && req.oe) begin
      dout <= mem[req.addr];
    end
  end

endmodule

// ==== verilog/axi_sram_ctrl.sv ====
`timescale 1ns/1ps
`include "axi_sram_config.svh"

module axi_sram_ctrl
  import axi_sram_pkg::*;
(
  input  logic                      clk,
  input  logic                      rstn,
  input  axi_aw_t                   aw,
  input  logic                      awvalid,
  output logic                      awready,
  input  axi_w_t                    w,
  input  logic                      wvalid,
  output logic                      wready,
  output axi_b_t                    b,
  output logic                      bvalid,
  input  logic                      bready,
  input  axi_ar_t                   ar,
  input  logic                      arvalid,
  output logic                      arready,
  output axi_r_t                    r,
  output logic                      rvalid,
  input  logic                      rready,
  output sram_req_t                 sram_req,
  input  logic [`AXI_DATA_BITS-1:0] dout
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  logic [`AXI_ID_BITS-1:0]    id_q;
  logic [`SRAM_ADDR_BITS-1:0] base_q;
  logic [`AXI_LEN_BITS-1:0]   len_q;
  logic [`AXI_LEN_BITS-1:0]   cnt_q;
  logic                       rvalid_q;
  logic                       last_beat;
  logic [`SRAM_ADDR_BITS-1:0] beat_addr;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;
  assign ar_hs = arvalid & arready;
  assign r_hs  = rvalid & rready;

  // ready and valid flags follow the state directly.
  // a pending write blocks the read address channel.
  assign awready = (state == st_idle);
  assign arready = (state == st_idle) & ~awvalid;
  assign wready  = (state == st_write);
  assign bvalid  = (state == st_resp);
  assign rvalid  = rvalid_q;

  assign last_beat = (cnt_q == len_q);

  // word address of the current beat, wraps at the top of memory.
  assign beat_addr = base_q + `SRAM_ADDR_BITS'(cnt_q);

  always_comb begin
    b.id   = id_q;
    b.resp = resp_okay;
  end

  always_comb begin
    r.id   = id_q;
    r.data = dout;
    r.resp = resp_okay;
    r.last = last_beat;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (aw_hs) begin
          state_nxt = st_write;
        end else if (ar_hs) begin
          state_nxt = st_read;
        end
      end
      st_write: begin
        // the beat flagged last ends the burst, whatever the count.
        if (w_hs && w.last) begin
          state_nxt = st_resp;
        end
      end
      st_resp: begin
        if (b_hs) begin
          state_nxt = st_idle;
        end
      end
      st_read: begin
        if (r_hs && last_beat) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  // beat counter, cleared when a new burst is accepted.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_q <= '0;
    end else if (aw_hs || ar_hs) begin
      cnt_q <= '0;
    end else if (w_hs || r_hs) begin
      cnt_q <= cnt_q + `AXI_LEN_BITS'(1);
    end
  end

  // dout is fresh one cycle after entering read and one cycle after each beat.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= (state == st_read) & ~r_hs;
    end
  end

  // burst attributes, captured on the address handshake.
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q   <= aw.id;
      base_q <= aw.addr[`SRAM_WORD_LSB +: `SRAM_ADDR_BITS];
      len_q  <= aw.len;
    end else if (ar_hs) begin
      id_q   <= ar.id;
      base_q <= ar.addr[`SRAM_WORD_LSB +: `SRAM_ADDR_BITS];
      len_q  <= ar.len;
    end
  end

  always_comb begin
    sram_req.cs   = 1'b0;
    sram_req.oe   = 1'b0;
    sram_req.web  = '1;
    sram_req.addr = beat_addr;
    sram_req.din  = w.data;
    case (state)
      st_idle: begin
        // first read of a burst goes out with the ar handshake.
        sram_req.cs   = ar_hs;
        sram_req.oe   = ar_hs;
        sram_req.addr = ar.addr[`SRAM_WORD_LSB +: `SRAM_ADDR_BITS];
      end
      st_write: begin
        sram_req.cs  = w_hs;
        sram_req.web = w_hs ? ~w.strb : '1;
      end
      st_read: begin
        // a stall re-reads the same word; a taken beat fetches the next one.
        sram_req.cs = 1'b1;
        sram_req.oe = 1'b1;
        if (r_hs && !last_beat) begin
          sram_req.addr = beat_addr + `SRAM_ADDR_BITS'(1);
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/axi_sram_top.sv ====
`timescale 1ns/1ps
`include "axi_sram_config.svh"

module axi_sram_top
  import axi_sram_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  axi_aw_t aw,
  input  logic    awvalid,
  output logic    awready,
  input  axi_w_t  w,
  input  logic    wvalid,
  output logic    wready,
  output axi_b_t  b,
  output logic    bvalid,
  input  logic    bready,
  input  axi_ar_t ar,
  input  logic    arvalid,
  output logic    arready,
  output axi_r_t  r,
  output logic    rvalid,
  input  logic    rready
);

  sram_req_t                 sram_req;
  logic [`AXI_DATA_BITS-1:0] dout;

  axi_sram_ctrl u_ctrl (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (aw),
    .awvalid  (awvalid),
    .awready  (awready),
    .w        (w),
    .wvalid   (wvalid),
    .wready   (wready),
    .b        (b),
    .bvalid   (bvalid),
    .bready   (bready),
    .ar       (ar),
    .arvalid  (arvalid),
    .arready  (arready),
    .r        (r),
    .rvalid   (rvalid),
    .rready   (rready),
    .sram_req (sram_req),
    .dout     (dout)
  );

  // 64 KiB backing store.
  sram_sp u_sram (
    .clk  (clk),
    .req  (sram_req),
    .dout (dout)
  );

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rstn
);

  // 100 ns period.
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset released on a falling edge after 8 cycles.
  initial begin
    rstn = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// ==== dv/tb_axi_sram.sv ====
`timescale 1ns/1ps
`include "axi_sram_config.svh"

module tb_axi_sram
  import axi_sram_pkg::*;
();

  localparam int NUM_TXN     = 200;
  localparam int CYCLE_LIMIT = 8 + NUM_TXN * 16 * 8;

  logic    clk;
  logic    rstn;
  axi_aw_t aw;
  logic    awvalid;
  logic    awready;
  axi_w_t  w;
  logic    wvalid;
  logic    wready;
  axi_b_t  b;
  logic    bvalid;
  logic    bready;
  axi_ar_t ar;
  logic    arvalid;
  logic    arready;
  axi_r_t  r;
  logic    rvalid;
  logic    rready;

  logic [31:0]               lcg_state = 32'hcd0c8d24;
  logic [`AXI_DATA_BITS-1:0] ref_mem [`SRAM_DEPTH];

  // the checker follows the read burst in flight beat by beat.
  logic [`SRAM_ADDR_BITS-1:0] rd_base;
  logic [`AXI_ID_BITS-1:0]    rd_id;
  int                         rd_len;
  int                         rd_beat;
  bit                         rd_busy;
  axi_r_t                     held_r;
  bit                         held_ok;

  int errors;
  int checks;
  int cycles;

  tb_clkgen u_clkgen (
    .clk  (clk),
    .rstn (rstn)
  );

  axi_sram_top dut0 (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // the upper bits have the longer period and move to the low half.
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic void ref_write(input logic [`SRAM_ADDR_BITS-1:0] word,
                                    input logic [`AXI_DATA_BITS-1:0] data,
                                    input logic [`AXI_STRB_BITS-1:0] strb);
    for (int i = 0; i < `AXI_STRB_BITS; i++) begin
      if (strb[i]) begin
        ref_mem[word][8*i +: 8] = data[8*i +: 8];
      end
    end
  endfunction

  function automatic logic [`AXI_DATA_BITS-1:0] ref_read(
    input logic [`SRAM_ADDR_BITS-1:0] word);
    return ref_mem[word];
  endfunction

  // mostly the bottom 64 words and now and then the top 8 so that bursts wrap.
  function automatic logic [`AXI_ADDR_BITS-1:0] pick_addr();
    logic [31:0]                rnd;
    logic [`SRAM_ADDR_BITS-1:0] word;
    rnd = lcg_next();
    if (rnd[7:5] == 3'd0) begin
      word = `SRAM_ADDR_BITS'(`SRAM_DEPTH - 8) + `SRAM_ADDR_BITS'(rnd[2:0]);
    end else begin
      word = `SRAM_ADDR_BITS'(rnd[13:8]);
    end
    return {rnd[31:16], word, 2'b00};
  endfunction

  function automatic void expect_ar_blocked();
    assert (!(arvalid && arready)) else begin
      errors++;
      $display("ERR %0t: arready high while a write is in progress", $time);
    end
  endfunction

  function automatic void open_read(input logic [`AXI_ADDR_BITS-1:0] addr, input int len,
                                    input logic [`AXI_ID_BITS-1:0] id);
    ar      = '{id: id, addr: addr, len: `AXI_LEN_BITS'(len)};
    rd_base = addr[`SRAM_WORD_LSB +: `SRAM_ADDR_BITS];
    rd_len  = len;
    rd_id   = id;
    rd_beat = 0;
    rd_busy = 1'b1;
  endfunction

  task automatic axi_write(input logic [`AXI_ADDR_BITS-1:0] addr, input int len,
                           input logic [`AXI_ID_BITS-1:0] id, input bit ar_waiting,
                           input bit full_strb);
    logic [`SRAM_ADDR_BITS-1:0] word;
    logic [`AXI_DATA_BITS-1:0]  data;
    logic [`AXI_STRB_BITS-1:0]  strb;
    bit                         b_seen;
    bit                         b_done;
    word = addr[`SRAM_WORD_LSB +: `SRAM_ADDR_BITS];
    @(negedge clk);
    aw      = '{id: id, addr: addr, len: `AXI_LEN_BITS'(len)};
    awvalid = 1'b1;
    arvalid = ar_waiting;
    do @(posedge clk); while (!awready);
    expect_ar_blocked();
    for (int beat = 0; beat <= len; beat++) begin
      @(negedge clk);
      awvalid = 1'b0;
      data    = lcg_next();
      strb    = full_strb ? '1 : `AXI_STRB_BITS'(lcg_next());
      w       = '{data: data, strb: strb, last: (beat == len)};
      wvalid  = 1'b1;
      do begin
        @(posedge clk);
        expect_ar_blocked();
      end while (!wready);
      ref_write(`SRAM_ADDR_BITS'(word + beat), data, strb);
    end
    @(negedge clk);
    wvalid = 1'b0;
    bready = (lcg_next() & 32'h3) != 0;
    b_seen = 1'b0;
    b_done = 1'b0;
    while (!b_done) begin
      @(posedge clk);
      expect_ar_blocked();
      if (b_seen) begin
        assert (bvalid) else begin
          errors++;
          $display("bvalid dropped before the write response was accepted");
        end
      end
      b_seen = b_seen | bvalid;
      if (bvalid && bready) begin
        b_done = 1'b1;
        checks++;
        assert (b.id === id && b.resp === resp_okay) else begin
          errors++;
          $display("ERR %0t: b id %0h resp %0d, expected id %0h okay", $time, b.id, b.resp, id);
        end
      end else begin
        @(negedge clk);
        bready = (lcg_next() & 32'h3) != 0;
      end
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  // waits for the ar handshake and then takes beats with random rready stalls.
  task automatic read_tail();
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    while (rd_busy) begin
      rready = (lcg_next() & 32'h3) != 0;
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  task automatic axi_read(input logic [`AXI_ADDR_BITS-1:0] addr, input int len,
                          input logic [`AXI_ID_BITS-1:0] id);
    @(negedge clk);
    open_read(addr, len, id);
    arvalid = 1'b1;
    read_tail();
  endtask

  // aw and ar go up together and the write has to win.
  task automatic write_read_race(input logic [`AXI_ADDR_BITS-1:0] addr, input int len,
                                 input logic [`AXI_ID_BITS-1:0] wid,
                                 input logic [`AXI_ID_BITS-1:0] rid);
    open_read(addr, len, rid);
    axi_write(addr, len, wid, 1'b1, 1'b0);
    read_tail();
  endtask

  always @(posedge clk) begin
    logic [`AXI_DATA_BITS-1:0] exp_data;
    if (rstn && rvalid) begin
      if (held_ok) begin
        assert (r === held_r) else begin
          errors++;
          $display("ERR %0t: read beat changed while rready was low", $time);
        end
      end
      held_ok = !rready;
      held_r  = r;
      if (rready) begin
        checks++;
        exp_data = ref_read(`SRAM_ADDR_BITS'(rd_base + rd_beat));
        assert (rd_busy) else begin
          errors++;
          $display("a read beat arrived with no read burst open");
        end
        assert (r.data === exp_data) else begin
          errors++;
          $display("ERR %0t: read data %08h, expected %08h on beat %0d", $time, r.data,
                   exp_data, rd_beat);
        end
        assert (r.id === rd_id && r.resp === resp_okay) else begin
          errors++;
          $display("ERR %0t: r id %0h resp %0d, expected id %0h okay", $time, r.id, r.resp,
                   rd_id);
        end
        if (rd_beat == rd_len) begin
          assert (r.last) else begin
            errors++;
            $display("a read burst of %0d beats ended without last", rd_len + 1);
          end
          rd_busy = 1'b0;
        end else begin
          assert (!r.last) else begin
            errors++;
            $display("ERR %0t: last set on beat %0d of len %0d", $time, rd_beat, rd_len);
          end
          rd_beat++;
        end
      end
    end else begin
      assert (!held_ok) else begin
        errors++;
        $display("rvalid dropped before the read beat was accepted");
      end
      held_ok = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      errors++;
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d, responses checked: %0d", errors, checks);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [31:0]               rnd;
    aw      = '0;
    awvalid = 1'b0;
    w       = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    ar      = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    @(posedge rstn);
    @(negedge clk);
    assert (!bvalid && !rvalid && !wready && awready) else begin
      errors++;
      $display("ERR %0t: after reset bvalid %0b rvalid %0b wready %0b awready %0b", $time,
               bvalid, rvalid, wready, awready);
    end
    // one full word out and back.
    addr = pick_addr();
    axi_write(addr, 0, 4'h3, 1'b0, 1'b1);
    axi_read(addr, 0, 4'h3);
    for (int n = 0; n < NUM_TXN; n++) begin
      rnd  = lcg_next();
      addr = pick_addr();
      case (rnd[5:4])
        2'd0: axi_write(addr, rnd[3:0], rnd[11:8], 1'b0, 1'b0);
        2'd1: axi_read(addr, rnd[3:0], rnd[11:8]);
        2'd2: begin
          axi_write(addr, rnd[3:0], rnd[11:8], 1'b0, 1'b0);
          axi_read(addr, rnd[3:0], rnd[15:12]);
        end
        default: write_read_race(addr, rnd[3:0], rnd[11:8], rnd[15:12]);
      endcase
    end
    @(negedge clk);
    $display("errors: %0d, responses checked: %0d", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/axi_sram_pkg.sv
verilog/sram_sp.sv
verilog/axi_sram_ctrl.sv
verilog/axi_sram_top.sv
dv/tb_clkgen.sv
dv/tb_axi_sram.sv
